/* files.f */
rtl/fmul_pkg.sv
rtl/fmul_unpack.sv
rtl/r4booth_pp_gen.sv
rtl/pp_csa_tree.sv
rtl/fmul_round_pack.sv
rtl/fmul_top.sv
dv/tb_fmul.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fmul
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_fmul.sv */
`default_nettype none

module tb_fmul import fmul_pkg::*;;

    logic        clk_i;
    logic        rst_n_i;
    logic        valid_i;
    fp32_t       a_i;
    fp32_t       b_i;
    logic        valid_o;
    fp32_t       result_o;
    fp_flags_t   flags_o;

    // Model results as {result, flags} pushed when valid_i is driven
    logic [35:0] exp_q[$];
    // Monitor cycle stamp of each accepted strobe
    int          issue_q[$];
    logic [31:0] lfsr_state;
    logic [35:0] mon_exp;
    int          mon_lat;
    int          cycle;
    int          results;
    int          mon_errors;
    int          tb_errors;
    int          tests;
    int          sent;
    int          err_mark;
    int          res_mark;
    string       test_name;

    fmul_top DUT (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .valid_i  (valid_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .flags_o  (flags_o)
    );

    always #10 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR with polynomial x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Exponent 96..159 keeps the product well inside the normal range
    function automatic logic [31:0] rand_normal();
        return {1'(rand_bits(1)), 8'(96 + rand_bits(6)), 23'(rand_bits(23))};
    endfunction

    // Integer reference with exact product then round to nearest even
    function automatic logic [35:0] model(input logic [31:0] a, input logic [31:0] b);
        int          ea;
        int          eb;
        int          e;
        int          shift;
        logic        sign;
        logic        any_nan;
        logic        any_inf;
        logic        any_zero;
        logic [47:0] prod;
        logic [47:0] rem;
        logic [47:0] half;
        logic [24:0] keep;
        sign     = a[31] ^ b[31];
        ea       = int'(a[30:23]);
        eb       = int'(b[30:23]);
        any_nan  = (ea == 255 && a[22:0] != 0) || (eb == 255 && b[22:0] != 0);
        any_inf  = (ea == 255 && a[22:0] == 0) || (eb == 255 && b[22:0] == 0);
        // Subnormals count as zero
        any_zero = (ea == 0) || (eb == 0);
        if (any_nan) return {QNAN, 4'b0000};
        if (any_inf && any_zero) return {QNAN, 4'b1000};
        if (any_inf) return {sign, 8'hFF, 23'd0, 4'b0000};
        if (any_zero) return {sign, 31'd0, 4'b0000};
        prod  = {1'b1, a[22:0]} * {1'b1, b[22:0]};
        // Keep 24 significand bits and the rest as remainder
        shift = prod[47] ? 24 : 23;
        e     = ea + eb - 127 + (prod[47] ? 1 : 0);
        keep  = 25'(prod >> shift);
        rem   = prod & ((48'd1 << shift) - 48'd1);
        half  = 48'd1 << (shift - 1);
        if (rem > half || (rem == half && keep[0])) keep = keep + 25'd1;
        if (keep[24]) begin
            keep = keep >> 1;
            e    = e + 1;
        end
        if (e >= 255) return {sign, 8'hFF, 23'd0, 4'b0101};
        if (e <= 0) return {sign, 31'd0, 4'b0011};
        return {sign, 8'(e), keep[22:0], 3'b000, rem != 0};
    endfunction

    task automatic send(input logic [31:0] a, input logic [31:0] b);
        @(posedge clk_i);
        valid_i <= 1'b1;
        a_i     <= a;
        b_i     <= b;
        exp_q.push_back(model(a, b));
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            valid_i <= 1'b0;
        end
    endtask

    // Wait until every queued result came back
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out in test %s, %0d results never came out",
                     test_name, exp_q.size());
            tb_errors++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        sent      = 0;
        err_mark  = tb_errors + mon_errors;
        res_mark  = results;
    endtask

    task automatic end_test();
        int n_res;
        n_res = results - res_mark;
        assert (n_res == sent) else begin
            $display("ERROR %s: expected %0d results, actual %0d", test_name, sent, n_res);
            tb_errors++;
        end
        $display("Test %s done: %0d sent, %0d checked, %0d errors",
                 test_name, sent, n_res, tb_errors + mon_errors - err_mark);
        tests++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Scoreboard sampling at the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        cycle = cycle + 1;
        if (rst_n_i && valid_i) issue_q.push_back(cycle);
        if (rst_n_i && valid_o) begin
            if (exp_q.size() == 0 || issue_q.size() == 0) begin
                $display("A result came out in test %s with no operation pending", test_name);
                mon_errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                mon_lat = cycle - issue_q.pop_front();
                results++;
                assert ({result_o, flags_o} == mon_exp) else begin
                    $display("ERROR %s: expected %h, actual %h",
                             test_name, mon_exp, {result_o, flags_o});
                    mon_errors++;
                end
                assert (mon_lat == 3) else begin
                    $display("ERROR %s: expected latency 3, actual %0d", test_name, mon_lat);
                    mon_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        a_i        = '0;
        b_i        = '0;
        lfsr_state = 32'd53;
        cycle      = 0;
        results    = 0;
        mon_errors = 0;
        tb_errors  = 0;
        tests      = 0;

        // valid_o low in reset and while idle after it
        begin_test("reset");
        for (int i = 0; i < 10; i++) begin
            if (i == 4) begin
                @(posedge clk_i);
                rst_n_i <= 1'b1;
            end
            @(negedge clk_i);
            assert (valid_o == 1'b0) else begin
                $display("ERROR %s: expected valid_o 0, actual %b", test_name, valid_o);
                tb_errors++;
            end
        end
        end_test();

        begin_test("random_normal");
        for (int i = 0; i < 300; i++) send(rand_normal(), rand_normal());
        idle(1);
        drain();
        end_test();

        begin_test("special");
        for (int i = 0; i < 8; i++) begin
            send({1'(rand_bits(1)), 31'd0}, rand_normal());
            send(rand_normal(), {1'(rand_bits(1)), 8'hFF, 23'd0});
            send({1'(rand_bits(1)), 8'hFF, 23'd0}, {1'(rand_bits(1)), 31'd0});
            send({1'b0, 8'hFF, 22'(rand_bits(22)), 1'b1}, rand_normal());
            // Subnormal operand
            send(rand_normal(), {1'(rand_bits(1)), 8'h00, 22'(rand_bits(22)), 1'b1});
        end
        idle(1);
        drain();
        end_test();

        begin_test("range");
        for (int i = 0; i < 20; i++) begin
            // Exponent sum well past 254 and then well below 1
            send({1'(rand_bits(1)), 8'(200 + rand_bits(5)), 23'(rand_bits(23))},
                 {1'(rand_bits(1)), 8'(190 + rand_bits(5)), 23'(rand_bits(23))});
            send({1'(rand_bits(1)), 8'(30 + rand_bits(5)), 23'(rand_bits(23))},
                 {1'(rand_bits(1)), 8'(30 + rand_bits(5)), 23'(rand_bits(23))});
            // Near both edges of the range
            send({1'(rand_bits(1)), 8'(56 + rand_bits(4)), 23'(rand_bits(23))},
                 {1'(rand_bits(1)), 8'd64, 23'(rand_bits(23))});
            send({1'(rand_bits(1)), 8'(190 + rand_bits(4)), 23'(rand_bits(23))},
                 {1'(rand_bits(1)), 8'd190, 23'(rand_bits(23))});
        end
        // Significand product 2^47 - 1 rounds up into the exponent
        send({1'b0, 8'd127, 23'h21E58F}, {1'b1, 8'd127, 23'h4A6691});
        // Same carry pushed into overflow and lifted out of underflow
        send({1'b0, 8'd254, 23'h21E58F}, {1'b0, 8'd127, 23'h4A6691});
        send({1'b1, 8'd64, 23'h21E58F}, {1'b0, 8'd63, 23'h4A6691});
        // Exact 1.0 * 1.0 just below the normal range
        send({1'b0, 8'd64, 23'd0}, {1'b0, 8'd63, 23'd0});
        idle(1);
        drain();
        end_test();

        // Random gaps where zero means back to back
        begin_test("throughput");
        for (int i = 0; i < 100; i++) begin
            send(rand_normal(), rand_normal());
            idle(int'(rand_bits(2)));
        end
        idle(1);
        drain();
        end_test();

        $display("Summary: %0d tests, %0d results checked, %0d errors",
                 tests, results, tb_errors + mon_errors);
        if (tb_errors + mon_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/fmul_top.sv */
`default_nettype none

module fmul_top import fmul_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  valid_i,
    input  wire fp32_t a_i,
    input  wire fp32_t b_i,
    output logic       valid_o,
    output fp32_t      result_o,
    output fp_flags_t  flags_o
);

    // Unpack -> Booth, same cycle
    logic [MANT_W-1:0] mant_a;
    logic [MANT_W-1:0] mant_b;
    // Side band, two cycles behind
    op_info_t          info;
    logic              info_valid;
    // Stage 1 and 2 registers
    pp_array_t         pp;
    csa_pair_t         csa;

    fmul_unpack u_unpack (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .mant_a_o     (mant_a),
        .mant_b_o     (mant_b),
        .info_o       (info),
        .info_valid_o (info_valid)
    );

    r4booth_pp_gen u_booth (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .mant_a_i (mant_a),
        .mant_b_i (mant_b),
        .pp_o     (pp)
    );

    pp_csa_tree u_tree (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pp_i    (pp),
        .csa_o   (csa)
    );

    fmul_round_pack u_round (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .csa_i        (csa),
        .info_i       (info),
        .info_valid_i (info_valid),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .valid_o      (valid_o)
    );

endmodule

`default_nettype wire

/* rtl/fmul_round_pack.sv */
`default_nettype none

module fmul_round_pack import fmul_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire csa_pair_t csa_i,
    input  wire op_info_t  info_i,
    input  wire logic      info_valid_i,
    output fp32_t          result_o,
    output fp_flags_t      flags_o,
    output logic           valid_o
);

    logic [PROD_W-1:0]        prod;
    logic [PROD_W-2:0]        norm;
    logic signed [ESUM_W-1:0] exp_n;
    logic signed [ESUM_W-1:0] exp_r;
    logic [FRAC_W-1:0]        frac_n;
    logic [FRAC_W-1:0]        frac_r;
    logic [MANT_W:0]          mant_r;
    logic                     guard;
    logic                     rnd;
    logic                     sticky;
    logic                     round_up;
    logic                     invalid;
    logic                     ovf;
    logic                     unf;
    fp32_t                    res_d;
    fp_flags_t                flg_d;

    //////////////////////////////////////////////////////////////////////
    // Final add and normalize
    //////////////////////////////////////////////////////////////////////

    // Exact product fits 48 bits so the low 48 of the pair are enough
    assign prod = csa_i.sum[PROD_W-1:0] + csa_i.carry[PROD_W-1:0];

    // Product in [1,4) has its leading one at bit 47 or 46
    // Hidden bit dropped from the window
    assign norm  = prod[PROD_W-1] ? prod[PROD_W-2:0] : {prod[PROD_W-3:0], 1'b0};
    assign exp_n = info_i.exp_sum + ESUM_W'(prod[PROD_W-1]);

    assign frac_n = norm[PROD_W-2 -: FRAC_W];
    assign guard  = norm[PROD_W-2-FRAC_W];
    assign rnd    = norm[PROD_W-3-FRAC_W];
    assign sticky = |norm[PROD_W-4-FRAC_W:0];

    //////////////////////////////////////////////////////////////////////
    // Round to nearest with ties to even
    //////////////////////////////////////////////////////////////////////

    assign round_up = guard & (rnd | sticky | frac_n[0]);
    assign mant_r   = {1'b0, 1'b1, frac_n} + (MANT_W + 1)'(round_up);

    // Carry out of 1.111..1 leaves a zero fraction and bumps the exponent
    assign frac_r = mant_r[FRAC_W-1:0];
    assign exp_r  = exp_n + ESUM_W'(mant_r[MANT_W]);

    assign ovf = exp_r >= EXP_MAX;
    // Anything at or below 0 flushes since there are no subnormal outputs
    assign unf = exp_r <= 0;

    // inf * 0
    assign invalid = info_i.is_inf & info_i.is_zero;

    //////////////////////////////////////////////////////////////////////
    // Special cases and packing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        res_d.sign = info_i.sign;
        res_d.exp  = exp_r[EXP_W-1:0];
        res_d.frac = frac_r;
        flg_d      = '0;

        // Priority goes NaN, inf, zero, then range limits
        if (info_i.is_nan || invalid) begin
            res_d         = fp32_t'(QNAN);
            flg_d.invalid = invalid;
        end else if (info_i.is_inf) begin
            res_d.exp  = '1;
            res_d.frac = '0;
        end else if (info_i.is_zero) begin
            res_d.exp  = '0;
            res_d.frac = '0;
        end else if (ovf) begin
            res_d.exp      = '1;
            res_d.frac     = '0;
            flg_d.overflow = 1'b1;
            flg_d.inexact  = 1'b1;
        end else if (unf) begin
            // Signed zero
            res_d.exp       = '0;
            res_d.frac      = '0;
            flg_d.underflow = 1'b1;
            flg_d.inexact   = 1'b1;
        end else begin
            flg_d.inexact = guard | rnd | sticky;
        end
    end

    // Stage 3 register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
            flags_o  <= '0;
            valid_o  <= 1'b0;
        end else begin
            result_o <= res_d;
            flags_o  <= flg_d;
            valid_o  <= info_valid_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/pp_csa_tree.sv */
`default_nettype none

module pp_csa_tree import fmul_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire pp_array_t pp_i,
    output csa_pair_t      csa_o
);

    // Rows left after a given number of 3:2 levels
    function automatic int rows_at(int lvl);
        int n;
        n = PP_NUM;
        for (int i = 0; i < lvl; i++) begin
            n = 2 * (n / 3) + n % 3;
        end
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Wallace levels
    //////////////////////////////////////////////////////////////////////

    // Level l holds rows_at(l) live rows, the rest tied to zero
    wire [PP_W-1:0] lvl [CSA_LVLS+1][PP_NUM];

    for (genvar r = 0; r < PP_NUM; r++) begin : g_in
        assign lvl[0][r] = pp_i[r];
    end

    for (genvar l = 0; l < CSA_LVLS; l++) begin : g_lvl
        localparam int N_IN  = rows_at(l);
        localparam int N_CSA = N_IN / 3;
        localparam int N_OUT = rows_at(l + 1);

        // Full-adder row per group of three
        for (genvar g = 0; g < N_CSA; g++) begin : g_csa
            wire [PP_W-1:0] x;
            wire [PP_W-1:0] y;
            wire [PP_W-1:0] z;
            wire [PP_W-1:0] maj;

            assign x   = lvl[l][3*g];
            assign y   = lvl[l][3*g+1];
            assign z   = lvl[l][3*g+2];
            assign maj = (x & y) | (x & z) | (y & z);

            assign lvl[l+1][2*g]   = x ^ y ^ z;
            // Carry weight is one up, top bit falls off modulo 2^49
            assign lvl[l+1][2*g+1] = {maj[PP_W-2:0], 1'b0};
        end

        // Leftover rows pass straight down
        for (genvar r = 0; r < N_IN - 3 * N_CSA; r++) begin : g_pass
            assign lvl[l+1][2*N_CSA+r] = lvl[l][3*N_CSA+r];
        end

        for (genvar r = N_OUT; r < PP_NUM; r++) begin : g_tie
            assign lvl[l+1][r] = '0;
        end
    end

    // Stage 2 register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            csa_o <= '0;
        end else begin
            csa_o.sum   <= lvl[CSA_LVLS][0];
            csa_o.carry <= lvl[CSA_LVLS][1];
        end
    end

endmodule

`default_nettype wire

/* rtl/r4booth_pp_gen.sv */
`default_nettype none

module r4booth_pp_gen import fmul_pkg::*; (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic [MANT_W-1:0] mant_a_i,
    input  wire logic [MANT_W-1:0] mant_b_i,
    output pp_array_t              pp_o
);

    //////////////////////////////////////////////////////////////////////
    // Radix-4 recoding of B
    //////////////////////////////////////////////////////////////////////

    // Digit table, triple is {b[2j+1], b[2j], b[2j-1]}
    //   000 ->  0     100 -> -2A
    //   001 -> +A     101 -> -A
    //   010 -> +A     110 -> -A
    //   011 -> +2A    111 ->  0 (all-ones row plus negate bit)

    // One zero below for b[-1], two on top so the last digit sees 0,0,b23
    wire [MANT_W+2:0] b_pad;
    // A with a zero on each side, window [p+1:p] picks A or 2A per bit
    wire [MANT_W+1:0] a_ext;

    wire [PP_NUM-1:0] one_x;
    wire [PP_NUM-1:0] two_x;
    wire [PP_NUM-1:0] neg;

    // 25 bits per row, wide enough for 2A
    wire [PP_NUM-1:0][MANT_W:0] row;

    pp_array_t pp_d;

    assign b_pad = {2'b00, mant_b_i, 1'b0};
    assign a_ext = {1'b0, mant_a_i, 1'b0};

    for (genvar j = 0; j < PP_NUM; j++) begin : g_digit
        wire [2:0] trip;

        assign trip     = b_pad[2*j+2 : 2*j];
        assign one_x[j] = trip[1] ^ trip[0];
        assign two_x[j] = (trip == 3'b011) || (trip == 3'b100);
        assign neg[j]   = trip[2];

        // Per-bit selector, inverted for negative digits
        for (genvar p = 0; p <= MANT_W; p++) begin : g_bit
            assign row[j][p] = ((one_x[j] & a_ext[p+1]) | (two_x[j] & a_ext[p])) ^ neg[j];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row placement with compressed sign extension
    //////////////////////////////////////////////////////////////////////

    // Row 0: {~s, s, s, row}
    // Row j: {1, ~s, row} at 2j, previous negate bit at 2(j-1)
    // Leading ones fold into 2^49 and drop out of the sum
    // Last row loses its top bits to truncation, its digit is never negative
    always_comb begin
        pp_d[0] = PP_W'({~neg[0], neg[0], neg[0], row[0]});
        for (int j = 1; j < PP_NUM; j++) begin
            pp_d[j] = (PP_W'({1'b1, ~neg[j], row[j]}) << (2 * j))
                    | (PP_W'(neg[j-1]) << (2 * j - 2));
        end
    end

    // Stage 1 register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pp_o <= '0;
        end else begin
            pp_o <= pp_d;
        end
    end

endmodule

`default_nettype wire

/* rtl/fmul_unpack.sv */
`default_nettype none

module fmul_unpack import fmul_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        valid_i,
    input  wire fp32_t       a_i,
    input  wire fp32_t       b_i,
    output logic [MANT_W-1:0] mant_a_o,
    output logic [MANT_W-1:0] mant_b_o,
    output op_info_t         info_o,
    output logic             info_valid_o
);

    //////////////////////////////////////////////////////////////////////
    // Operand classification
    //////////////////////////////////////////////////////////////////////

    logic     a_zero;
    logic     b_zero;
    logic     a_inf;
    logic     b_inf;
    logic     a_nan;
    logic     b_nan;
    op_info_t info_d;
    op_info_t info_q;
    logic     valid_q;

    // Exponent 0 covers true zero and subnormals, both flushed
    assign a_zero = (a_i.exp == '0);
    assign b_zero = (b_i.exp == '0);

    // All-ones exponent, fraction tells inf from NaN
    assign a_inf  = (a_i.exp == '1) && (a_i.frac == '0);
    assign b_inf  = (b_i.exp == '1) && (b_i.frac == '0);
    assign a_nan  = (a_i.exp == '1) && (a_i.frac != '0);
    assign b_nan  = (b_i.exp == '1) && (b_i.frac != '0);

    // Hidden bit restored, flushed operands give an all-zero significand
    assign mant_a_o = a_zero ? '0 : {1'b1, a_i.frac};
    assign mant_b_o = b_zero ? '0 : {1'b1, b_i.frac};

    //////////////////////////////////////////////////////////////////////
    // Side-band word
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        info_d.sign    = a_i.sign ^ b_i.sign;
        // Wraps modulo 2^ESUM_W, read back as signed
        info_d.exp_sum = ESUM_W'(a_i.exp) + ESUM_W'(b_i.exp) - ESUM_W'(EXP_BIAS);
        info_d.is_zero = a_zero | b_zero;
        info_d.is_inf  = a_inf | b_inf;
        info_d.is_nan  = a_nan | b_nan;
    end

    // Two stages, lines up with the registered CSA pair
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            info_q       <= '0;
            info_o       <= '0;
            valid_q      <= 1'b0;
            info_valid_o <= 1'b0;
        end else begin
            info_q       <= info_d;
            info_o       <= info_q;
            valid_q      <= valid_i;
            info_valid_o <= valid_q;
        end
    end

endmodule

`default_nettype wire

/* rtl/fmul_pkg.sv */
`default_nettype none

package fmul_pkg;

    //////////////////////////////////////////////////////////////////////
    // binary32 format
    //////////////////////////////////////////////////////////////////////

    // Significand with hidden bit
    localparam int MANT_W   = 24;
    localparam int FRAC_W   = 23;
    localparam int EXP_W    = 8;
    localparam int EXP_BIAS = 127;
    // All-ones exponent, reserved for inf and NaN
    localparam int EXP_MAX  = 255;
    // Two spare bits so the exponent sum can go negative or past 255
    localparam int ESUM_W   = EXP_W + 2;

    // Canonical quiet NaN
    localparam logic [31:0] QNAN = 32'h7FC0_0000;

    //////////////////////////////////////////////////////////////////////
    // Booth array and reduction tree
    //////////////////////////////////////////////////////////////////////

    // 24-bit multiplier -> 13 radix-4 digits
    localparam int PP_NUM   = 13;
    // 24 + 24 + 1 for the 2x select
    localparam int PP_W     = 49;
    localparam int PROD_W   = 48;
    // 13 -> 9 -> 6 -> 4 -> 3 -> 2
    localparam int CSA_LVLS = 5;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // Side-band word, travels next to the Booth/CSA stages
    typedef struct packed {
        logic                     sign;
        // exp_a + exp_b - bias, still biased once
        logic signed [ESUM_W-1:0] exp_sum;
        logic                     is_zero;
        logic                     is_inf;
        logic                     is_nan;
    } op_info_t;

    typedef logic [PP_NUM-1:0][PP_W-1:0] pp_array_t;

    typedef struct packed {
        logic [PP_W-1:0] sum;
        logic [PP_W-1:0] carry;
    } csa_pair_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

endpackage

`default_nettype wire
